//--- Makefile
# Verilator build and run for the UART image link

VERILATOR ?= verilator
TOP       ?= tb_image_link
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM        = V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_image_link.sv
// Testbench tb_image_link with UART tasks, LFSR data, compare tasks and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_image_link;

  localparam int CLK_FREQ    = 1_000_000;
  localparam int BAUD        = 125_000;
  localparam int BUF_DEPTH   = 16;
  localparam int CPB         = CLK_FREQ / BAUD;
  localparam int CLK_NS      = 4;
  localparam int NUM_TESTS   = 5;
  // 20 frames of 10 bits for each test, plus the reset time
  localparam int WATCHDOG_NS = NUM_TESTS * 20 * 10 * CPB * CLK_NS + 16 * CLK_NS;
  localparam int START_LIMIT = 20 * CPB;
  localparam int BUSY_LIMIT  = 4 * CPB;

  logic                  CLOCK_50;
  logic                  DLY_RST_0;
  logic                  rxd;
  logic                  store_mode;
  logic                  send_n;
  logic                  txd;
  logic                  busy;
  link_pkg::frame_addr_t image_base;
  logic                  disp_rst_n;

  int              errors;
  int              checks;
  int              pulse_cnt;
  logic [7:0]      lfsr_state;
  link_pkg::byte_t buf_model [BUF_DEPTH];
  int              wr_model;

  image_link_top #(
    .CLK_FREQ  (CLK_FREQ),
    .BAUD      (BAUD),
    .BUF_DEPTH (BUF_DEPTH)
  ) i_dut (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rxd        (rxd),
    .store_mode (store_mode),
    .send_n     (send_n),
    .txd        (txd),
    .busy       (busy),
    .image_base (image_base),
    .disp_rst_n (disp_rst_n)
  );

  always #(CLK_NS / 2) CLOCK_50 = ~CLOCK_50;

  // Low cycles of the display reset
  always @(negedge CLOCK_50) begin
    if (DLY_RST_0 && !disp_rst_n) pulse_cnt = pulse_cnt + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // ======================================================================
  // Compare tasks
  // ======================================================================
  task automatic compare_byte(input link_pkg::byte_t got, input link_pkg::byte_t exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_addr(input link_pkg::frame_addr_t got,
                              input link_pkg::frame_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // ======================================================================
  // Stimulus and models
  // ======================================================================
  // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic random_byte(output link_pkg::byte_t b);
    for (int i = 0; i < 8; i++) begin
      b[i]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Slot n starts FRAME_WORDS words after slot n-1, indices past the last clamp
  function automatic link_pkg::frame_addr_t expected_base(input int idx);
    int clamped;
    int base;
    clamped = (idx > link_pkg::MAX_IMAGE) ? link_pkg::MAX_IMAGE : idx;
    base    = int'(link_pkg::FRAME_BASE) + clamped * int'(link_pkg::FRAME_WORDS);
    return link_pkg::frame_addr_t'(base);
  endfunction

  task automatic send_byte(input link_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge CLOCK_50);
      rxd <= frame[i];
      repeat (CPB - 1) @(posedge CLOCK_50);
    end
  endtask

  task automatic hold_idle(input int bits);
    repeat (bits * CPB) @(posedge CLOCK_50);
  endtask

  task automatic recv_byte(output link_pkg::byte_t b, output logic ok);
    int waited;
    waited = 0;
    b      = '0;
    ok     = 1'b0;
    @(negedge CLOCK_50);
    while (txd !== 1'b0 && waited < START_LIMIT) begin
      @(negedge CLOCK_50);
      waited++;
    end
    if (txd !== 1'b0) begin
      errors++;
      $display("No start bit on txd within %0d clock cycles", START_LIMIT);
    end else begin
      // Near the middle of the start bit
      repeat (CPB / 2 - 1) @(negedge CLOCK_50);
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge CLOCK_50);
        b[i] = txd;
      end
      repeat (CPB) @(negedge CLOCK_50);
      compare_bit(txd, 1'b1, "txd stop bit");
      ok = 1'b1;
    end
  endtask

  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    @(negedge CLOCK_50);
    while (busy !== level && waited < BUSY_LIMIT) begin
      @(negedge CLOCK_50);
      waited++;
    end
    if (busy !== level) begin
      errors++;
      $display("busy did not go to %0b within %0d clock cycles", level, BUSY_LIMIT);
    end
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================
  task automatic check_after_reset();
    @(negedge CLOCK_50);
    compare_bit(txd, 1'b1, "txd after reset");
    compare_bit(busy, 1'b0, "busy after reset");
    compare_bit(disp_rst_n, 1'b1, "disp_rst_n after reset");
    compare_addr(image_base, link_pkg::FRAME_BASE, "image_base after reset");
  endtask

  task automatic select_image();
    @(posedge CLOCK_50);
    store_mode <= 1'b0;
    pulse_cnt = 0;
    send_byte(8'd5);
    hold_idle(2);
    @(negedge CLOCK_50);
    compare_addr(image_base, expected_base(5), "image_base for index 5");
    compare_bit(pulse_cnt == 1, 1'b1, "single display reset on a new index");
    pulse_cnt = 0;
    send_byte(8'd5);
    hold_idle(2);
    @(negedge CLOCK_50);
    compare_addr(image_base, expected_base(5), "image_base for repeated index 5");
    compare_bit(pulse_cnt == 0, 1'b1, "no display reset on a repeated index");
  endtask

  task automatic clamp_index();
    send_byte(8'd200);
    hold_idle(2);
    @(negedge CLOCK_50);
    compare_addr(image_base, expected_base(200), "image_base for index 200");
  endtask

  task automatic store_then_send(input string tag, input int num_bytes);
    link_pkg::byte_t       b;
    link_pkg::frame_addr_t base_before;
    logic                  ok;
    @(posedge CLOCK_50);
    store_mode <= 1'b1;
    @(negedge CLOCK_50);
    base_before = image_base;
    for (int i = 0; i < num_bytes; i++) begin
      random_byte(b);
      buf_model[wr_model] = b;
      wr_model = (wr_model + 1) % BUF_DEPTH;
      send_byte(b);
      hold_idle(1);
      @(negedge CLOCK_50);
      compare_addr(image_base, base_before,
                   $sformatf("%s image_base while storing byte %0d", tag, i));
    end
    hold_idle(1);
    @(negedge CLOCK_50);
    compare_bit(busy, 1'b0, {tag, " busy before send"});
    // Short press on the send button
    @(posedge CLOCK_50);
    send_n <= 1'b0;
    repeat (2) @(posedge CLOCK_50);
    send_n <= 1'b1;
    wait_busy(1'b1);
    for (int i = 0; i < BUF_DEPTH; i++) begin
      recv_byte(b, ok);
      if (ok) compare_byte(b, buf_model[i], $sformatf("%s byte %0d on txd", tag, i));
    end
    wait_busy(1'b0);
    // Write pointer starts over once a send has finished
    wr_model = 0;
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    CLOCK_50   = 1'b0;
    DLY_RST_0  = 1'b0;
    rxd        = 1'b1;
    store_mode = 1'b0;
    send_n     = 1'b1;
    errors     = 0;
    checks     = 0;
    pulse_cnt  = 0;
    lfsr_state = 8'd22;
    wr_model   = 0;

    repeat (16) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;

    check_after_reset();
    select_image();
    clamp_index();
    // Three extra bytes wrap onto the start and leave the pointer at 3
    store_then_send("first send", BUF_DEPTH + 3);
    // Pointer back at 0, so new data must come out from the start
    store_then_send("second send", BUF_DEPTH);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/link_pkg.sv
source/uart_rx_framer.sv
source/image_selector.sv
source/tx_buffer.sv
source/uart_tx_serializer.sv
source/image_link_top.sv
dv/tb_image_link.sv

//--- source/image_link_top.sv
// Module image_link_top, UART image link with receiver, selector, buffer, transmitter
`timescale 1ns/100ps
`default_nettype none

module image_link_top #(
  parameter int CLK_FREQ  = 50_000_000,
  parameter int BAUD      = 115_200,
  parameter int BUF_DEPTH = 1024
) (
  input  wire                   CLOCK_50,
  input  wire                   DLY_RST_0,
  input  wire                   rxd,
  input  wire                   store_mode,
  input  wire                   send_n,
  output logic                  txd,
  output logic                  busy,
  output link_pkg::frame_addr_t image_base,
  output logic                  disp_rst_n
);

  link_pkg::byte_t rx_byte;
  logic            rx_valid;
  link_pkg::byte_t tx_byte;
  logic            tx_req;
  logic            tx_ack;

  // ======================================================================
  // Producer
  // ======================================================================
  uart_rx_framer #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD     (BAUD)
  ) i_rx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (rxd),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid)
  );

  image_selector i_sel (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .store_mode (store_mode),
    .image_base (image_base),
    .disp_rst_n (disp_rst_n)
  );

  // ======================================================================
  // Buffer and consumer
  // ======================================================================
  tx_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_buf (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .store_mode (store_mode),
    .send_n     (send_n),
    .tx_byte    (tx_byte),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .busy       (busy)
  );

  uart_tx_serializer #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD     (BAUD)
  ) i_tx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_byte   (tx_byte),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .txd       (txd)
  );

endmodule

`default_nettype wire

//--- source/image_selector.sv
// Module image_selector, current image index, frame base address, display reset
`timescale 1ns/100ps
`default_nettype none

module image_selector (
  input  wire                   CLOCK_50,
  input  wire                   DLY_RST_0,
  input  wire link_pkg::byte_t  rx_byte,
  input  wire                   rx_valid,
  input  wire                   store_mode,
  output link_pkg::frame_addr_t image_base,
  output logic                  disp_rst_n
);

  localparam int IDX_W = $clog2(link_pkg::MAX_IMAGE + 1);

  logic [IDX_W-1:0] cur_idx;
  logic [IDX_W-1:0] idx_next;

  // Out-of-range requests land on the last stored picture
  assign idx_next = (rx_byte > link_pkg::byte_t'(link_pkg::MAX_IMAGE)) ?
                    IDX_W'(link_pkg::MAX_IMAGE) : rx_byte[IDX_W-1:0];

  // ======================================================================
  // Index register and change pulse
  // ======================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_idx    <= '0;
      disp_rst_n <= 1'b1;
    end else begin
      disp_rst_n <= 1'b1;
      if (rx_valid && !store_mode && idx_next != cur_idx) begin
        cur_idx    <= idx_next;
        // Pulse lines up with the new base address
        disp_rst_n <= 1'b0;
      end
    end
  end

  // Linear slot layout
  assign image_base = link_pkg::FRAME_BASE +
                      link_pkg::frame_addr_t'(cur_idx) * link_pkg::FRAME_WORDS;

  a_disp_pulse_single : assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) !disp_rst_n |=> disp_rst_n
  );

endmodule

`default_nettype wire

//--- source/link_pkg.sv
// Package link_pkg with byte and frame-address types and frame-memory constants
`default_nettype none

package link_pkg;

  // ======================================================================
  // UART byte
  // ======================================================================
  localparam int BYTE_W = 8;

  typedef logic [BYTE_W-1:0] byte_t;

  // ======================================================================
  // External frame memory
  // ======================================================================
  localparam int ADDR_W = 23;

  typedef logic [ADDR_W-1:0] frame_addr_t;

  // Start of image 0 in frame memory
  localparam frame_addr_t FRAME_BASE = 23'h050000;

  // 320 x 240 words per stored picture
  localparam frame_addr_t FRAME_WORDS = 23'd76800;

  // Images 0 .. 46 are stored
  localparam int MAX_IMAGE = 46;

endpackage

`default_nettype wire

//--- source/tx_buffer.sv
// Module tx_buffer, byte RAM with write pointer, send trigger and req/ack read-out
`timescale 1ns/100ps
`default_nettype none

module tx_buffer #(
  parameter int BUF_DEPTH = 1024
) (
  input  wire                  CLOCK_50,
  input  wire                  DLY_RST_0,
  input  wire link_pkg::byte_t rx_byte,
  input  wire                  rx_valid,
  input  wire                  store_mode,
  input  wire                  send_n,
  output link_pkg::byte_t      tx_byte,
  output logic                 tx_req,
  input  wire                  tx_ack,
  output logic                 busy
);

  localparam int AW = $clog2(BUF_DEPTH);

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_REQ, S_ACK_LOW} rd_state_t;

  link_pkg::byte_t mem [BUF_DEPTH];
  rd_state_t       state;
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic            send_meta;
  logic            send_s;
  logic            send_q;
  logic            send_fall;
  logic            wr_en;

  assign busy      = (state != S_IDLE);
  assign send_fall = send_q && !send_s;
  assign wr_en     = rx_valid && store_mode && !busy;

  // Button is asynchronous to the clock
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      send_meta <= 1'b1;
      send_s    <= 1'b1;
      send_q    <= 1'b1;
    end else begin
      send_meta <= send_n;
      send_s    <= send_meta;
      send_q    <= send_s;
    end
  end

  // ======================================================================
  // Storage
  // ======================================================================
  always_ff @(posedge CLOCK_50) begin
    if (wr_en) mem[wr_ptr] <= rx_byte;
  end

  // Registered read port, rd_ptr holds steady for the whole handshake
  always_ff @(posedge CLOCK_50) begin
    tx_byte <= mem[rd_ptr];
  end

  // ======================================================================
  // Write pointer and read-out FSM
  // ======================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state  <= S_IDLE;
      wr_ptr <= '0;
      rd_ptr <= '0;
      tx_req <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == AW'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      case (state)
        S_IDLE: begin
          if (send_fall) begin
            rd_ptr <= '0;
            state  <= S_LOAD;
          end
        end
        S_LOAD: begin
          tx_req <= 1'b1;
          state  <= S_REQ;
        end
        S_REQ: begin
          if (tx_ack) begin
            tx_req <= 1'b0;
            state  <= S_ACK_LOW;
          end
        end
        default: begin
          // Ack stays high until the stop bit is out
          if (!tx_ack) begin
            if (rd_ptr == AW'(BUF_DEPTH - 1)) begin
              wr_ptr <= '0;
              state  <= S_IDLE;
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
              state  <= S_LOAD;
            end
          end
        end
      endcase
    end
  end

  a_ack_needs_req : assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) $rose(tx_ack) |-> $past(tx_req)
  );

endmodule

`default_nettype wire

//--- source/uart_rx_framer.sv
// Module uart_rx_framer, UART receiver with mid-bit sampling and byte strobe
`timescale 1ns/100ps
`default_nettype none

module uart_rx_framer #(
  parameter int CLK_FREQ = 50_000_000,
  parameter int BAUD     = 115_200
) (
  input  wire             CLOCK_50,
  input  wire             DLY_RST_0,
  input  wire             rxd,
  output link_pkg::byte_t rx_byte,
  output logic            rx_valid
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t       state;
  logic            rx_meta;
  logic            rx_s;
  logic            rx_prev;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]      bit_idx;
  link_pkg::byte_t data_sr;
  logic            bit_tick;

  assign bit_tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign rx_byte  = data_sr;

  // Two-flop synchronizer, plus one more stage for the edge detect
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_s    <= rx_meta;
      rx_prev <= rx_s;
    end
  end

  // ======================================================================
  // Frame FSM
  // ======================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= bit_tick ? '0 : clk_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (rx_prev && !rx_s) state <= RX_START;
        end
        RX_START: begin
          // Middle of the start bit, restart the bit timer from here
          if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end
        end
        default: begin
          // Low stop bit means a framing error, the byte is dropped
          if (bit_tick) begin
            state    <= RX_IDLE;
            rx_valid <= rx_s;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state == RX_DATA && bit_tick) data_sr <= {rx_s, data_sr[7:1]};
  end

  a_rx_valid_single : assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) rx_valid |=> !rx_valid
  );

endmodule

`default_nettype wire

//--- source/uart_tx_serializer.sv
// Module uart_tx_serializer, UART transmitter fed by a four-phase handshake
`timescale 1ns/100ps
`default_nettype none

module uart_tx_serializer #(
  parameter int CLK_FREQ = 50_000_000,
  parameter int BAUD     = 115_200
) (
  input  wire                  CLOCK_50,
  input  wire                  DLY_RST_0,
  input  wire link_pkg::byte_t tx_byte,
  input  wire                  tx_req,
  output logic                 tx_ack,
  output logic                 txd
);

  localparam int CLKS_PER_BIT = CLK_FREQ / BAUD;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_RELEASE} tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;
  logic [8:0]       shift_q;
  logic             bit_tick;
  logic             accept;

  assign bit_tick = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign accept   = (state == TX_IDLE) && tx_req;

  // Data bits then the stop bit, shifted out LSB first
  always_ff @(posedge CLOCK_50) begin
    if (accept) begin
      shift_q <= {1'b1, tx_byte};
    end else if (state == TX_SEND && bit_tick) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  // ======================================================================
  // Frame FSM
  // ======================================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_ack  <= 1'b0;
      txd     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (accept) begin
            tx_ack <= 1'b1;
            txd    <= 1'b0;
            state  <= TX_SEND;
          end
        end
        TX_SEND: begin
          clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
          if (bit_tick) begin
            // Ten bit times from the start edge
            if (bit_idx == 4'd9) begin
              state <= TX_RELEASE;
            end else begin
              txd     <= shift_q[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: begin
          if (!tx_req) begin
            tx_ack <= 1'b0;
            state  <= TX_IDLE;
          end
        end
      endcase
    end
  end

  a_req_held : assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) tx_req && !tx_ack |=> tx_req
  );

endmodule

`default_nettype wire
